// ==== hw/cpu_data_arbiter.sv ====
`timescale 1ns/1ns

module cpu_data_arbiter (
  input  logic                               intack,
  input  logic                               addr_oe,
  input  logic [7:0]                         cur_addr,
  input  logic [zxuno_reg_pkg::NUM_REGS-1:0] reg_oe,
  input  logic [7:0]                         reg_value [zxuno_reg_pkg::NUM_REGS],
  output logic [7:0]                         cpu_din
);

  import zxuno_bus_pkg::*;
  import zxuno_reg_pkg::*;

  data_t reg_byte;
  logic  reg_any;

  // ----------------------------------------
  // Register sources
  // ----------------------------------------

  // Addresses are distinct, so at most one register answers
  always_comb begin
    reg_byte = FLOATING_BYTE;
    reg_any  = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (reg_oe[i]) begin
        reg_byte = reg_value[i];
        reg_any  = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Fixed priority onto the CPU input
  // ----------------------------------------

  always_comb begin
    if (intack) begin
      cpu_din = INTACK_BYTE;
    end else if (addr_oe) begin
      cpu_din = cur_addr;
    end else if (reg_any) begin
      cpu_din = reg_byte;
    end else begin
      // Nothing drives the bus, it floats high
      cpu_din = FLOATING_BYTE;
    end
  end

  // Two registers answering the same address
  always_comb begin
    a_oe_onehot: assert final ($onehot0(reg_oe));
  end

endmodule

// ==== hw/zxuno_bus_pkg.sv ====
package zxuno_bus_pkg;

  // ----------------------------------------
  // CPU side of the bus
  // ----------------------------------------

  // One byte on the CPU data bus
  typedef logic [7:0] data_t;

  // Z80 bus as the CPU drives it, strobes active low
  typedef struct packed {
    logic [15:0] addr;
    data_t       dout;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } cpu_bus_t;

  // ----------------------------------------
  // I/O ports of the register bank
  // ----------------------------------------

  // Register address port
  localparam logic [15:0] PORT_REG_ADDR = 16'hFC3B;
  // Register data port
  localparam logic [15:0] PORT_REG_DATA = 16'hFD3B;

  // Kind of cycle seen on the bus
  typedef enum logic [1:0] {
    ACC_NONE,
    ACC_READ,
    ACC_WRITE,
    ACC_INTACK
  } bus_access_e;

  // Byte forced on the data bus during an interrupt acknowledge
  localparam data_t INTACK_BYTE = 8'hFF;

  // Pull-up value when nobody drives the bus
  localparam data_t FLOATING_BYTE = 8'hFF;

endpackage

// ==== hw/zxuno_option_reg.sv ====
`timescale 1ns/1ns

module zxuno_option_reg #(
  parameter zxuno_reg_pkg::reg_id_e REG_ID = zxuno_reg_pkg::REG_SCRATCH
) (
  input  logic       sysclk,
  input  logic       arst_n,
  input  logic [7:0] cur_addr,
  input  logic       reg_rd,
  input  logic       reg_wr,
  input  logic [7:0] wr_data,
  output logic [7:0] value,
  output logic       oe
);

  import zxuno_bus_pkg::*;
  import zxuno_reg_pkg::*;

  logic  selected;
  data_t next_value;

  // ----------------------------------------
  // Address match and read enable
  // ----------------------------------------

  assign selected = (cur_addr == REG_ADDR[REG_ID]);

  // Drive the CPU only during a data-port read
  assign oe = reg_rd && selected;

  // ----------------------------------------
  // Masked update
  // ----------------------------------------

  // Write only the bits the mask allows
  assign next_value = (value & ~REG_WMASK[REG_ID]) |
                      (wr_data & REG_WMASK[REG_ID]);

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      value <= REG_RESET[REG_ID];
    end else if (reg_wr && selected) begin
      value <= next_value;
    end
  end

  // Contents only move on a decoder strobe
  a_value_hold: assert property (
    @(posedge sysclk) disable iff (!arst_n)
    !reg_wr |=> $stable(value)
  );

endmodule

// ==== hw/zxuno_port_decoder.sv ====
`timescale 1ns/1ns

module zxuno_port_decoder (
  input  logic                   sysclk,
  input  logic                   arst_n,
  input  zxuno_bus_pkg::cpu_bus_t cpu_bus,
  output logic [7:0]             cur_addr,
  output logic                   addr_oe,
  output logic                   reg_rd,
  output logic                   reg_wr,
  output logic [7:0]             wr_data,
  output logic                   intack
);

  import zxuno_bus_pkg::*;
  import zxuno_reg_pkg::*;

  bus_access_e access;
  logic        hit_addr_port;
  logic        hit_data_port;
  logic        addr_write;
  logic        data_write;
  logic        data_write_q;
  logic        data_write_rise;

  // ----------------------------------------
  // Bus cycle classification
  // ----------------------------------------

  // Intack wins, the Z80 raises no rd_n or wr_n during it anyway
  always_comb begin
    access = ACC_NONE;
    if (!cpu_bus.iorq_n && !cpu_bus.m1_n) begin
      access = ACC_INTACK;
    end else if (!cpu_bus.iorq_n && !cpu_bus.rd_n) begin
      access = ACC_READ;
    end else if (!cpu_bus.iorq_n && !cpu_bus.wr_n) begin
      access = ACC_WRITE;
    end
  end

  assign hit_addr_port = (cpu_bus.addr == PORT_REG_ADDR);
  assign hit_data_port = (cpu_bus.addr == PORT_REG_DATA);

  assign addr_write = (access == ACC_WRITE) && hit_addr_port;
  assign data_write = (access == ACC_WRITE) && hit_data_port;

  // Reads are served straight from current state
  assign addr_oe = (access == ACC_READ) && hit_addr_port;
  assign reg_rd  = (access == ACC_READ) && hit_data_port;
  assign intack  = (access == ACC_INTACK);

  // ----------------------------------------
  // Address register and write strobe
  // ----------------------------------------

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      cur_addr <= CUR_ADDR_RESET;
    end else if (addr_write) begin
      cur_addr <= cpu_bus.dout;
    end
  end

  // First cycle of a data-port write
  assign data_write_rise = data_write && !data_write_q;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      data_write_q <= 1'b0;
      reg_wr       <= 1'b0;
    end else begin
      data_write_q <= data_write;
      reg_wr       <= data_write_rise;
    end
  end

  // Byte travels with the strobe
  always_ff @(posedge sysclk) begin
    if (data_write_rise) begin
      wr_data <= cpu_bus.dout;
    end
  end

  // A long write gives one strobe only
  a_wr_single: assert property (
    @(posedge sysclk) disable iff (!arst_n)
    reg_wr |=> !reg_wr
  );

  // Strobe from a past write never meets a present read
  a_rd_wr_excl: assert property (
    @(posedge sysclk) disable iff (!arst_n)
    !(reg_rd && reg_wr)
  );

endmodule

// ==== hw/zxuno_reg_pkg.sv ====
package zxuno_reg_pkg;

  // ----------------------------------------
  // Register bank layout
  // ----------------------------------------

  localparam int NUM_REGS = 4;

  // Value of the address register after reset
  localparam logic [7:0] CUR_ADDR_RESET = 8'h00;

  // Position in the tables below
  typedef enum logic [1:0] {
    REG_SCRATCH,
    REG_DEVOPTIONS,
    REG_DEVCTRL2,
    REG_CAPS
  } reg_id_e;

  // Register address as written to the address port
  localparam logic [7:0] REG_ADDR [NUM_REGS] = '{
    8'hFE,
    8'h0E,
    8'h0F,
    8'hFF
  };

  localparam logic [7:0] REG_RESET [NUM_REGS] = '{
    8'h00,
    8'h00,
    8'h00,
    8'h5A
  };

  // 1 marks a writable bit, others hold their value
  localparam logic [7:0] REG_WMASK [NUM_REGS] = '{
    8'hFF,
    8'hFF,
    8'h1F,
    8'h00
  };

  // ----------------------------------------
  // Device options fanned out of the bank
  // ----------------------------------------

  typedef struct packed {
    // Device-enable register, bits 0 to 7
    logic       disable_ay;
    logic       disable_turboay;
    logic       disable_7ffd;
    logic       disable_1ffd;
    logic       disable_romsel7f;
    logic       disable_romsel1f;
    logic       enable_timexmmu;
    logic       disable_spisd;
    // Second control register, bits 0 to 4
    logic       disable_timexscr;
    logic       disable_ulaplus;
    logic       disable_radas;
    logic       disable_specdrum;
    logic       disable_mixer;
    logic [2:0] pad;
  } dev_options_t;

endpackage

// ==== hw/zxuno_regbank.sv ====
`timescale 1ns/1ns

module zxuno_regbank (
  input  logic                        sysclk,
  input  logic                        arst_n,
  input  zxuno_bus_pkg::cpu_bus_t     cpu_bus,
  output logic [7:0]                  cpu_din,
  output zxuno_reg_pkg::dev_options_t dev_options
);

  import zxuno_bus_pkg::*;
  import zxuno_reg_pkg::*;

  data_t               cur_addr;
  data_t               wr_data;
  logic                addr_oe;
  logic                reg_rd;
  logic                reg_wr;
  logic                intack;
  logic [NUM_REGS-1:0] reg_oe;
  data_t               reg_value [NUM_REGS];
  data_t               devopt;
  data_t               devctrl2;

  zxuno_port_decoder u_decoder (
    .sysclk   (sysclk  ),
    .arst_n   (arst_n  ),
    .cpu_bus  (cpu_bus ),
    .cur_addr (cur_addr),
    .addr_oe  (addr_oe ),
    .reg_rd   (reg_rd  ),
    .reg_wr   (reg_wr  ),
    .wr_data  (wr_data ),
    .intack   (intack  )
  );

  // One register per table entry
  for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
    zxuno_option_reg #(
      .REG_ID (reg_id_e'(i))
    ) u_reg (
      .sysclk   (sysclk      ),
      .arst_n   (arst_n      ),
      .cur_addr (cur_addr    ),
      .reg_rd   (reg_rd      ),
      .reg_wr   (reg_wr      ),
      .wr_data  (wr_data     ),
      .value    (reg_value[i]),
      .oe       (reg_oe[i]   )
    );
  end

  cpu_data_arbiter u_arbiter (
    .intack    (intack   ),
    .addr_oe   (addr_oe  ),
    .cur_addr  (cur_addr ),
    .reg_oe    (reg_oe   ),
    .reg_value (reg_value),
    .cpu_din   (cpu_din  )
  );

  // ----------------------------------------
  // Device option fan-out
  // ----------------------------------------

  assign devopt   = reg_value[REG_DEVOPTIONS];
  assign devctrl2 = reg_value[REG_DEVCTRL2];

  assign dev_options.disable_ay       = devopt[0];
  assign dev_options.disable_turboay  = devopt[1];
  assign dev_options.disable_7ffd     = devopt[2];
  assign dev_options.disable_1ffd     = devopt[3];
  assign dev_options.disable_romsel7f = devopt[4];
  assign dev_options.disable_romsel1f = devopt[5];
  assign dev_options.enable_timexmmu  = devopt[6];
  assign dev_options.disable_spisd    = devopt[7];

  // Only the low 5 bits of the second register exist
  assign dev_options.disable_timexscr = devctrl2[0];
  assign dev_options.disable_ulaplus  = devctrl2[1];
  assign dev_options.disable_radas    = devctrl2[2];
  assign dev_options.disable_specdrum = devctrl2[3];
  assign dev_options.disable_mixer    = devctrl2[4];
  assign dev_options.pad              = 3'b000;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the register bank testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_zxuno_regbank \
  -Mdir "$BUILD_DIR" \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# The log decides the result
if grep -q "Verification failed" "$LOG_FILE"; then
  exit 1
fi

exit 0

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic sysclk,
  output logic arst_n
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 10;
  localparam int DRIVE_DELAY  = 10;

  initial begin
    sysclk = 1'b0;
    forever #HALF_PERIOD sysclk = ~sysclk;
  end

  // Reset leaves just after an edge, like any other input
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge sysclk);
    #DRIVE_DELAY;
    arst_n = 1'b1;
  end

endmodule

// ==== test/tb_zxuno_regbank.sv ====
`timescale 1ns/1ns

module tb_zxuno_regbank;

  import zxuno_bus_pkg::*;
  import zxuno_reg_pkg::*;

  localparam int RESET_TIMEOUT = 40;
  localparam int RUN_LIMIT     = 2000;
  localparam int DRIVE_DELAY   = 10;
  localparam int SAMPLE_DELAY  = 30;

  logic         sysclk;
  logic         arst_n;
  cpu_bus_t     cpu_bus;
  data_t        cpu_din;
  dev_options_t dev_options;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_bad;
  int     test_errs_start;
  logic   reset_done;
  data_t  shadow [NUM_REGS];

  tb_clock_gen u_clk (
    .sysclk (sysclk),
    .arst_n (arst_n)
  );

  zxuno_regbank u_dut (
    .sysclk      (sysclk     ),
    .arst_n      (arst_n     ),
    .cpu_bus     (cpu_bus    ),
    .cpu_din     (cpu_din    ),
    .dev_options (dev_options)
  );

  // ----------------------------------------
  // Z80 style bus cycles
  // ----------------------------------------

  task automatic next_cycle();
    @(posedge sysclk);
    #DRIVE_DELAY;
  endtask

  task automatic bus_idle();
    cpu_bus.addr   = 16'h0000;
    cpu_bus.dout   = 8'h00;
    cpu_bus.iorq_n = 1'b1;
    cpu_bus.rd_n   = 1'b1;
    cpu_bus.wr_n   = 1'b1;
    cpu_bus.m1_n   = 1'b1;
  endtask

  // Three cycles of access, then one idle
  task automatic io_write(input logic [15:0] port, input data_t data);
    cpu_bus.addr   = port;
    cpu_bus.dout   = data;
    cpu_bus.iorq_n = 1'b0;
    cpu_bus.wr_n   = 1'b0;
    for (int i = 0; i < 3; i++) begin
      next_cycle();
    end
    bus_idle();
    next_cycle();
  endtask

  task automatic io_read(input logic [15:0] port, output data_t data);
    cpu_bus.addr   = port;
    cpu_bus.iorq_n = 1'b0;
    cpu_bus.rd_n   = 1'b0;
    next_cycle();
    next_cycle();
    // Mid third cycle
    #SAMPLE_DELAY;
    data = cpu_din;
    next_cycle();
    bus_idle();
    next_cycle();
  endtask

  // M1 first, IORQ one cycle later
  task automatic intack_cycle(output data_t data);
    cpu_bus.m1_n = 1'b0;
    next_cycle();
    cpu_bus.iorq_n = 1'b0;
    next_cycle();
    #SAMPLE_DELAY;
    data = cpu_din;
    next_cycle();
    bus_idle();
    next_cycle();
  endtask

  task automatic write_reg(input int idx, input data_t data);
    io_write(PORT_REG_ADDR, REG_ADDR[idx]);
    io_write(PORT_REG_DATA, data);
    shadow[idx] = (shadow[idx] & ~REG_WMASK[idx]) | (data & REG_WMASK[idx]);
  endtask

  task automatic read_reg(input int idx, output data_t data);
    io_write(PORT_REG_ADDR, REG_ADDR[idx]);
    io_read(PORT_REG_DATA, data);
  endtask

  // ----------------------------------------
  // Checks and bookkeeping
  // ----------------------------------------

  task automatic check_byte(input string name, input data_t got, input data_t exp);
    assert (got == exp) else begin
      $display("Error: time %0t, %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_options(input dev_options_t exp);
    assert (dev_options == exp) else begin
      $display("Error: time %0t, dev_options = 0x%04h, expected 0x%04h",
               $time, dev_options, exp);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_errs_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_errs_start) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_errs_start);
    end
  endtask

  // Both register values mapped onto the named fields
  function automatic dev_options_t expected_options(input data_t devopt, input data_t ctrl2);
    dev_options_t exp;
    exp                  = '0;
    exp.disable_ay       = devopt[0];
    exp.disable_turboay  = devopt[1];
    exp.disable_7ffd     = devopt[2];
    exp.disable_1ffd     = devopt[3];
    exp.disable_romsel7f = devopt[4];
    exp.disable_romsel1f = devopt[5];
    exp.enable_timexmmu  = devopt[6];
    exp.disable_spisd    = devopt[7];
    exp.disable_timexscr = ctrl2[0];
    exp.disable_ulaplus  = ctrl2[1];
    exp.disable_radas    = ctrl2[2];
    exp.disable_specdrum = ctrl2[3];
    exp.disable_mixer    = ctrl2[4];
    return exp;
  endfunction

  task automatic wait_reset_release(output logic released);
    int cycles;
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge sysclk);
      cycles++;
    end
    released = (arst_n === 1'b1);
    if (released) begin
      next_cycle();
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------

  task automatic test_reset_values();
    data_t got;
    begin_test();
    for (int i = 0; i < NUM_REGS; i++) begin
      read_reg(i, got);
      check_byte($sformatf("cpu_din reg 0x%02h", REG_ADDR[i]), got, REG_RESET[i]);
    end
    check_options('0);
    end_test("reset values");
  endtask

  task automatic test_addr_readback();
    logic [31:0] r;
    data_t       addr;
    data_t       got;
    begin_test();
    for (int i = 0; i < 4; i++) begin
      r    = $random(seed);
      addr = r[7:0];
      io_write(PORT_REG_ADDR, addr);
      io_read(PORT_REG_ADDR, got);
      check_byte("cpu_din addr port", got, addr);
    end
    end_test("address port readback");
  endtask

  task automatic test_masked_writes();
    logic [31:0] r;
    data_t       got;
    begin_test();
    for (int i = 0; i < NUM_REGS; i++) begin
      r = $random(seed);
      write_reg(i, r[7:0]);
      read_reg(i, got);
      check_byte($sformatf("cpu_din reg 0x%02h", REG_ADDR[i]), got, shadow[i]);
    end
    read_reg(REG_CAPS, got);
    check_byte("cpu_din caps", got, 8'h5A);
    end_test("masked writes");
  endtask

  task automatic test_dev_options();
    logic [31:0] r;
    begin_test();
    for (int pass = 0; pass < 2; pass++) begin
      r = $random(seed);
      if (pass == 0) begin
        write_reg(REG_DEVOPTIONS, r[7:0]);
        write_reg(REG_DEVCTRL2, r[15:8]);
      end else begin
        // All ones in both registers
        write_reg(REG_DEVOPTIONS, 8'hFF);
        write_reg(REG_DEVCTRL2, 8'hFF);
      end
      check_options(expected_options(shadow[REG_DEVOPTIONS], shadow[REG_DEVCTRL2]));
    end
    end_test("device options");
  endtask

  task automatic test_floating_bus();
    data_t got;
    begin_test();
    io_write(PORT_REG_ADDR, 8'h10);
    io_read(PORT_REG_DATA, got);
    check_byte("cpu_din unmapped reg", got, 8'hFF);
    io_read(16'h00FE, got);
    check_byte("cpu_din other port", got, 8'hFF);
    end_test("floating bus");
  endtask

  task automatic test_intack();
    data_t got;
    begin_test();
    write_reg(REG_SCRATCH, 8'h3C);
    // Data-port read held on the bus so the scratch byte competes
    cpu_bus.addr = PORT_REG_DATA;
    cpu_bus.rd_n = 1'b0;
    intack_cycle(got);
    check_byte("cpu_din intack", got, INTACK_BYTE);
    // Address still points at the scratch register
    io_read(PORT_REG_DATA, got);
    check_byte("cpu_din scratch", got, shadow[REG_SCRATCH]);
    end_test("interrupt acknowledge");
  endtask

  // ----------------------------------------
  // Sequence and watchdog
  // ----------------------------------------

  initial begin
    seed      = 68161;
    errors    = 0;
    tests_run = 0;
    tests_bad = 0;
    bus_idle();
    for (int i = 0; i < NUM_REGS; i++) begin
      shadow[i] = REG_RESET[i];
    end
    wait_reset_release(reset_done);
    if (!reset_done) begin
      $display("Timeout: reset was still asserted after %0d cycles", RESET_TIMEOUT);
      $display("Verification failed");
    end else begin
      test_reset_values();
      test_addr_readback();
      test_masked_writes();
      test_dev_options();
      test_floating_bus();
      test_intack();
      $display("Summary: %0d tests run, %0d with errors, %0d failed checks",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
    end
    $finish;
  end

  initial begin
    for (int c = 0; c < RUN_LIMIT; c++) begin
      @(posedge sysclk);
    end
    $display("Timeout: the run went past %0d clock cycles", RUN_LIMIT);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/zxuno_bus_pkg.sv
hw/zxuno_reg_pkg.sv
hw/zxuno_port_decoder.sv
hw/zxuno_option_reg.sv
hw/cpu_data_arbiter.sv
hw/zxuno_regbank.sv
test/tb_clock_gen.sv
test/tb_zxuno_regbank.sv
